// ==== common/icb_pkg.sv ====
//------------------------------------------------------------
// ICB bus definitions.
// Address and data widths, payload field types and the
// read/write opcode shared by the bus blocks.
//------------------------------------------------------------

package icb_pkg;

  // Bus widths.
  localparam int ICB_AW = 32;
  localparam int ICB_DW = 32;

  // Command address.
  typedef logic [ICB_AW-1:0] icb_addr_t;

  // Read and write data.
  typedef logic [ICB_DW-1:0] icb_data_t;

  // One mask bit per data byte.
  typedef logic [ICB_DW/8-1:0] icb_mask_t;

  // Transfer size, 0 byte, 1 halfword, 2 word.
  typedef logic [1:0] icb_size_t;

  // Command opcode, matches the ICB read flag.
  typedef enum logic {
    ICB_WRITE = 1'b0,
    ICB_READ  = 1'b1
  } icb_op_e;

endpackage

// ==== common/arbt_pkg.sv ====
//------------------------------------------------------------
// Arbiter definitions.
// Scheme select, requester identifier and the last-grant
// state used by the round-robin pointer.
//------------------------------------------------------------

package arbt_pkg;

  // Arbitration scheme.
  typedef enum logic {
    ARBT_FIXED       = 1'b0,
    ARBT_ROUND_ROBIN = 1'b1
  } arbt_scheme_e;

  // Requester number, 0 or 1.
  typedef logic arbt_src_t;

  // Requester that took the last grant.
  typedef enum logic {
    ARBT_LAST_I0 = 1'b0,
    ARBT_LAST_I1 = 1'b1
  } arbt_state_e;

endpackage

// ==== icb_arbt/icb_arbt.sv ====
//------------------------------------------------------------
// ICB command arbiter.
// Picks one of two requesters per command, under fixed
// priority or round robin, and reports each grant.
//------------------------------------------------------------

module icb_arbt #(
  parameter arbt_pkg::arbt_scheme_e ARBT_SCHEME = arbt_pkg::ARBT_ROUND_ROBIN
) (
  input  logic                clk,
  input  logic                i_reset,

  input  logic                i_i0_cmd_valid,
  output logic                o_i0_cmd_ready,
  input  icb_pkg::icb_op_e    i_i0_cmd_op,
  input  icb_pkg::icb_addr_t  i_i0_cmd_addr,
  input  icb_pkg::icb_data_t  i_i0_cmd_wdata,
  input  icb_pkg::icb_mask_t  i_i0_cmd_wmask,
  input  icb_pkg::icb_size_t  i_i0_cmd_size,

  input  logic                i_i1_cmd_valid,
  output logic                o_i1_cmd_ready,
  input  icb_pkg::icb_op_e    i_i1_cmd_op,
  input  icb_pkg::icb_addr_t  i_i1_cmd_addr,
  input  icb_pkg::icb_data_t  i_i1_cmd_wdata,
  input  icb_pkg::icb_mask_t  i_i1_cmd_wmask,
  input  icb_pkg::icb_size_t  i_i1_cmd_size,

  output logic                o_cmd_valid,
  input  logic                i_cmd_ready,
  output icb_pkg::icb_op_e    o_cmd_op,
  output icb_pkg::icb_addr_t  o_cmd_addr,
  output icb_pkg::icb_data_t  o_cmd_wdata,
  output icb_pkg::icb_mask_t  o_cmd_wmask,
  output icb_pkg::icb_size_t  o_cmd_size,

  input  logic                i_route_full,
  output logic                o_grant,
  output arbt_pkg::arbt_src_t o_grant_src
);

  import icb_pkg::*;
  import arbt_pkg::*;

  arbt_state_e last_q;
  arbt_src_t   sel_src;
  logic        any_valid;
  logic        path_open;

  assign any_valid = i_i0_cmd_valid | i_i1_cmd_valid;

  // A command may move only if the buffer takes it and the
  // response queue has room to record its source.
  assign path_open = i_cmd_ready & ~i_route_full;

  always_comb begin
    if (i_i0_cmd_valid && i_i1_cmd_valid) begin
      if (ARBT_SCHEME == ARBT_ROUND_ROBIN) begin
        // The requester not served last wins the tie.
        sel_src = (last_q == ARBT_LAST_I0) ? 1'b1 : 1'b0;
      end else begin
        sel_src = 1'b0;
      end
    end else begin
      sel_src = i_i1_cmd_valid ? 1'b1 : 1'b0;
    end
  end

  // Payload mux.
  assign o_cmd_op    = sel_src ? i_i1_cmd_op    : i_i0_cmd_op;
  assign o_cmd_addr  = sel_src ? i_i1_cmd_addr  : i_i0_cmd_addr;
  assign o_cmd_wdata = sel_src ? i_i1_cmd_wdata : i_i0_cmd_wdata;
  assign o_cmd_wmask = sel_src ? i_i1_cmd_wmask : i_i0_cmd_wmask;
  assign o_cmd_size  = sel_src ? i_i1_cmd_size  : i_i0_cmd_size;

  // Valid is held back while the queue is full, so the buffer
  // never takes a command without a grant.
  assign o_cmd_valid = any_valid & ~i_route_full;

  assign o_i0_cmd_ready = ~sel_src & path_open;
  assign o_i1_cmd_ready = sel_src & path_open;

  assign o_grant     = any_valid & path_open;
  assign o_grant_src = sel_src;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      last_q <= ARBT_LAST_I1;
    end else if (o_grant) begin
      last_q <= sel_src ? ARBT_LAST_I1 : ARBT_LAST_I0;
    end
  end

endmodule

// ==== icb_arbt/icb_rsp_route.sv ====
//------------------------------------------------------------
// ICB response router.
// Queues the source of each granted command and sends each
// response back to that source, in issue order.
//------------------------------------------------------------

module icb_rsp_route #(
  parameter int OUTS_NUM = 2
) (
  input  logic                clk,
  input  logic                i_reset,

  input  logic                i_grant,
  input  arbt_pkg::arbt_src_t i_grant_src,
  output logic                o_full,

  input  logic                i_rsp_valid,
  output logic                o_rsp_ready,
  input  logic                i_rsp_err,
  input  icb_pkg::icb_data_t  i_rsp_rdata,

  output logic                o_i0_rsp_valid,
  input  logic                i_i0_rsp_ready,
  output logic                o_i0_rsp_err,
  output icb_pkg::icb_data_t  o_i0_rsp_rdata,

  output logic                o_i1_rsp_valid,
  input  logic                i_i1_rsp_ready,
  output logic                o_i1_rsp_err,
  output icb_pkg::icb_data_t  o_i1_rsp_rdata
);

  import arbt_pkg::*;

  localparam int PTR_W = (OUTS_NUM > 1) ? $clog2(OUTS_NUM) : 1;
  localparam int CNT_W = $clog2(OUTS_NUM + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(OUTS_NUM - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(OUTS_NUM);

  arbt_src_t        src_q [OUTS_NUM];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  arbt_src_t        head_src;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  assign o_full   = (cnt_q == FULL_CNT);
  assign head_src = src_q[rd_ptr_q];

  // Steer toward the oldest outstanding source.
  assign o_i0_rsp_valid = i_rsp_valid & ~head_src;
  assign o_i1_rsp_valid = i_rsp_valid & head_src;
  assign o_rsp_ready    = head_src ? i_i1_rsp_ready : i_i0_rsp_ready;

  assign o_i0_rsp_err   = i_rsp_err;
  assign o_i0_rsp_rdata = i_rsp_rdata;
  assign o_i1_rsp_err   = i_rsp_err;
  assign o_i1_rsp_rdata = i_rsp_rdata;

  assign pop = i_rsp_valid & o_rsp_ready;

  always_ff @(posedge clk) begin
    if (i_grant) begin
      src_q[wr_ptr_q] <= i_grant_src;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (i_grant) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({i_grant, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

// ==== rtl/icb_buffer.sv ====
//------------------------------------------------------------
// ICB buffer stage.
// Registered command and response FIFOs between the
// arbiter and the slave port, ready taken from the count.
//------------------------------------------------------------

module icb_buffer #(
  parameter int FIFO_DP = 2
) (
  input  logic               clk,
  input  logic               i_reset,

  // Commands from the arbiter.
  input  logic               i_cmd_valid,
  output logic               o_cmd_ready,
  input  icb_pkg::icb_op_e   i_cmd_op,
  input  icb_pkg::icb_addr_t i_cmd_addr,
  input  icb_pkg::icb_data_t i_cmd_wdata,
  input  icb_pkg::icb_mask_t i_cmd_wmask,
  input  icb_pkg::icb_size_t i_cmd_size,

  // Commands to the slave.
  output logic               o_cmd_valid,
  input  logic               i_cmd_ready,
  output icb_pkg::icb_op_e   o_cmd_op,
  output icb_pkg::icb_addr_t o_cmd_addr,
  output icb_pkg::icb_data_t o_cmd_wdata,
  output icb_pkg::icb_mask_t o_cmd_wmask,
  output icb_pkg::icb_size_t o_cmd_size,

  // Responses from the slave.
  input  logic               i_rsp_valid,
  output logic               o_rsp_ready,
  input  logic               i_rsp_err,
  input  icb_pkg::icb_data_t i_rsp_rdata,

  // Responses to the router.
  output logic               o_rsp_valid,
  input  logic               i_rsp_ready,
  output logic               o_rsp_err,
  output icb_pkg::icb_data_t o_rsp_rdata
);

  import icb_pkg::*;

  localparam int PTR_W = (FIFO_DP > 1) ? $clog2(FIFO_DP) : 1;
  localparam int CNT_W = $clog2(FIFO_DP + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DP - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DP);

  icb_op_e          op_mem    [FIFO_DP];
  icb_addr_t        addr_mem  [FIFO_DP];
  icb_data_t        wdata_mem [FIFO_DP];
  icb_mask_t        wmask_mem [FIFO_DP];
  icb_size_t        size_mem  [FIFO_DP];
  logic [PTR_W-1:0] cmd_wr_ptr_q;
  logic [PTR_W-1:0] cmd_rd_ptr_q;
  logic [CNT_W-1:0] cmd_cnt_q;
  logic             cmd_push;
  logic             cmd_pop;

  logic             err_mem   [FIFO_DP];
  icb_data_t        rdata_mem [FIFO_DP];
  logic [PTR_W-1:0] rsp_wr_ptr_q;
  logic [PTR_W-1:0] rsp_rd_ptr_q;
  logic [CNT_W-1:0] rsp_cnt_q;
  logic             rsp_push;
  logic             rsp_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // Command FIFO.
  assign o_cmd_ready = (cmd_cnt_q != FULL_CNT);
  assign o_cmd_valid = (cmd_cnt_q != '0);
  assign cmd_push    = i_cmd_valid & o_cmd_ready;
  assign cmd_pop     = o_cmd_valid & i_cmd_ready;

  assign o_cmd_op    = op_mem[cmd_rd_ptr_q];
  assign o_cmd_addr  = addr_mem[cmd_rd_ptr_q];
  assign o_cmd_wdata = wdata_mem[cmd_rd_ptr_q];
  assign o_cmd_wmask = wmask_mem[cmd_rd_ptr_q];
  assign o_cmd_size  = size_mem[cmd_rd_ptr_q];

  always_ff @(posedge clk) begin
    if (cmd_push) begin
      op_mem[cmd_wr_ptr_q]    <= i_cmd_op;
      addr_mem[cmd_wr_ptr_q]  <= i_cmd_addr;
      wdata_mem[cmd_wr_ptr_q] <= i_cmd_wdata;
      wmask_mem[cmd_wr_ptr_q] <= i_cmd_wmask;
      size_mem[cmd_wr_ptr_q]  <= i_cmd_size;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      cmd_wr_ptr_q <= '0;
      cmd_rd_ptr_q <= '0;
      cmd_cnt_q    <= '0;
    end else begin
      if (cmd_push) begin
        cmd_wr_ptr_q <= ptr_inc(cmd_wr_ptr_q);
      end
      if (cmd_pop) begin
        cmd_rd_ptr_q <= ptr_inc(cmd_rd_ptr_q);
      end
      case ({cmd_push, cmd_pop})
        2'b10:   cmd_cnt_q <= cmd_cnt_q + 1'b1;
        2'b01:   cmd_cnt_q <= cmd_cnt_q - 1'b1;
        default: cmd_cnt_q <= cmd_cnt_q;
      endcase
    end
  end

  // Response FIFO.
  assign o_rsp_ready = (rsp_cnt_q != FULL_CNT);
  assign o_rsp_valid = (rsp_cnt_q != '0);
  assign rsp_push    = i_rsp_valid & o_rsp_ready;
  assign rsp_pop     = o_rsp_valid & i_rsp_ready;

  assign o_rsp_err   = err_mem[rsp_rd_ptr_q];
  assign o_rsp_rdata = rdata_mem[rsp_rd_ptr_q];

  always_ff @(posedge clk) begin
    if (rsp_push) begin
      err_mem[rsp_wr_ptr_q]   <= i_rsp_err;
      rdata_mem[rsp_wr_ptr_q] <= i_rsp_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      rsp_wr_ptr_q <= '0;
      rsp_rd_ptr_q <= '0;
      rsp_cnt_q    <= '0;
    end else begin
      if (rsp_push) begin
        rsp_wr_ptr_q <= ptr_inc(rsp_wr_ptr_q);
      end
      if (rsp_pop) begin
        rsp_rd_ptr_q <= ptr_inc(rsp_rd_ptr_q);
      end
      case ({rsp_push, rsp_pop})
        2'b10:   rsp_cnt_q <= rsp_cnt_q + 1'b1;
        2'b01:   rsp_cnt_q <= rsp_cnt_q - 1'b1;
        default: rsp_cnt_q <= rsp_cnt_q;
      endcase
    end
  end

endmodule

// ==== rtl/icb2to1_bus.sv ====
//------------------------------------------------------------
// Two-master to one-slave ICB bus.
// Arbiter, buffer stage and response router joined into
// one port pair toward the slave.
//------------------------------------------------------------

module icb2to1_bus #(
  parameter arbt_pkg::arbt_scheme_e ARBT_SCHEME = arbt_pkg::ARBT_ROUND_ROBIN,
  parameter int OUTS_NUM = 2,
  parameter int FIFO_DP  = 2
) (
  input  logic               clk,
  input  logic               i_reset,

  input  logic               i_i0_cmd_valid,
  output logic               o_i0_cmd_ready,
  input  icb_pkg::icb_op_e   i_i0_cmd_op,
  input  icb_pkg::icb_addr_t i_i0_cmd_addr,
  input  icb_pkg::icb_data_t i_i0_cmd_wdata,
  input  icb_pkg::icb_mask_t i_i0_cmd_wmask,
  input  icb_pkg::icb_size_t i_i0_cmd_size,
  output logic               o_i0_rsp_valid,
  input  logic               i_i0_rsp_ready,
  output logic               o_i0_rsp_err,
  output icb_pkg::icb_data_t o_i0_rsp_rdata,

  input  logic               i_i1_cmd_valid,
  output logic               o_i1_cmd_ready,
  input  icb_pkg::icb_op_e   i_i1_cmd_op,
  input  icb_pkg::icb_addr_t i_i1_cmd_addr,
  input  icb_pkg::icb_data_t i_i1_cmd_wdata,
  input  icb_pkg::icb_mask_t i_i1_cmd_wmask,
  input  icb_pkg::icb_size_t i_i1_cmd_size,
  output logic               o_i1_rsp_valid,
  input  logic               i_i1_rsp_ready,
  output logic               o_i1_rsp_err,
  output icb_pkg::icb_data_t o_i1_rsp_rdata,

  output logic               o_mem_cmd_valid,
  input  logic               i_mem_cmd_ready,
  output icb_pkg::icb_op_e   o_mem_cmd_op,
  output icb_pkg::icb_addr_t o_mem_cmd_addr,
  output icb_pkg::icb_data_t o_mem_cmd_wdata,
  output icb_pkg::icb_mask_t o_mem_cmd_wmask,
  output icb_pkg::icb_size_t o_mem_cmd_size,
  input  logic               i_mem_rsp_valid,
  output logic               o_mem_rsp_ready,
  input  logic               i_mem_rsp_err,
  input  icb_pkg::icb_data_t i_mem_rsp_rdata
);

  import icb_pkg::*;
  import arbt_pkg::*;

  // Arbiter to buffer.
  logic      arbt_cmd_valid;
  logic      arbt_cmd_ready;
  icb_op_e   arbt_cmd_op;
  icb_addr_t arbt_cmd_addr;
  icb_data_t arbt_cmd_wdata;
  icb_mask_t arbt_cmd_wmask;
  icb_size_t arbt_cmd_size;

  // Arbiter to router.
  logic      grant;
  arbt_src_t grant_src;
  logic      route_full;

  // Buffer to router.
  logic      buf_rsp_valid;
  logic      buf_rsp_ready;
  logic      buf_rsp_err;
  icb_data_t buf_rsp_rdata;

  icb_arbt #(
    .ARBT_SCHEME (ARBT_SCHEME)
  ) u_icb_arbt (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_i0_cmd_valid (i_i0_cmd_valid),
    .o_i0_cmd_ready (o_i0_cmd_ready),
    .i_i0_cmd_op    (i_i0_cmd_op),
    .i_i0_cmd_addr  (i_i0_cmd_addr),
    .i_i0_cmd_wdata (i_i0_cmd_wdata),
    .i_i0_cmd_wmask (i_i0_cmd_wmask),
    .i_i0_cmd_size  (i_i0_cmd_size),
    .i_i1_cmd_valid (i_i1_cmd_valid),
    .o_i1_cmd_ready (o_i1_cmd_ready),
    .i_i1_cmd_op    (i_i1_cmd_op),
    .i_i1_cmd_addr  (i_i1_cmd_addr),
    .i_i1_cmd_wdata (i_i1_cmd_wdata),
    .i_i1_cmd_wmask (i_i1_cmd_wmask),
    .i_i1_cmd_size  (i_i1_cmd_size),
    .o_cmd_valid    (arbt_cmd_valid),
    .i_cmd_ready    (arbt_cmd_ready),
    .o_cmd_op       (arbt_cmd_op),
    .o_cmd_addr     (arbt_cmd_addr),
    .o_cmd_wdata    (arbt_cmd_wdata),
    .o_cmd_wmask    (arbt_cmd_wmask),
    .o_cmd_size     (arbt_cmd_size),
    .i_route_full   (route_full),
    .o_grant        (grant),
    .o_grant_src    (grant_src)
  );

  icb_rsp_route #(
    .OUTS_NUM (OUTS_NUM)
  ) u_icb_rsp_route (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_grant        (grant),
    .i_grant_src    (grant_src),
    .o_full         (route_full),
    .i_rsp_valid    (buf_rsp_valid),
    .o_rsp_ready    (buf_rsp_ready),
    .i_rsp_err      (buf_rsp_err),
    .i_rsp_rdata    (buf_rsp_rdata),
    .o_i0_rsp_valid (o_i0_rsp_valid),
    .i_i0_rsp_ready (i_i0_rsp_ready),
    .o_i0_rsp_err   (o_i0_rsp_err),
    .o_i0_rsp_rdata (o_i0_rsp_rdata),
    .o_i1_rsp_valid (o_i1_rsp_valid),
    .i_i1_rsp_ready (i_i1_rsp_ready),
    .o_i1_rsp_err   (o_i1_rsp_err),
    .o_i1_rsp_rdata (o_i1_rsp_rdata)
  );

  icb_buffer #(
    .FIFO_DP (FIFO_DP)
  ) u_icb_buffer (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_cmd_valid (arbt_cmd_valid),
    .o_cmd_ready (arbt_cmd_ready),
    .i_cmd_op    (arbt_cmd_op),
    .i_cmd_addr  (arbt_cmd_addr),
    .i_cmd_wdata (arbt_cmd_wdata),
    .i_cmd_wmask (arbt_cmd_wmask),
    .i_cmd_size  (arbt_cmd_size),
    .o_cmd_valid (o_mem_cmd_valid),
    .i_cmd_ready (i_mem_cmd_ready),
    .o_cmd_op    (o_mem_cmd_op),
    .o_cmd_addr  (o_mem_cmd_addr),
    .o_cmd_wdata (o_mem_cmd_wdata),
    .o_cmd_wmask (o_mem_cmd_wmask),
    .o_cmd_size  (o_mem_cmd_size),
    .i_rsp_valid (i_mem_rsp_valid),
    .o_rsp_ready (o_mem_rsp_ready),
    .i_rsp_err   (i_mem_rsp_err),
    .i_rsp_rdata (i_mem_rsp_rdata),
    .o_rsp_valid (buf_rsp_valid),
    .i_rsp_ready (buf_rsp_ready),
    .o_rsp_err   (buf_rsp_err),
    .o_rsp_rdata (buf_rsp_rdata)
  );

endmodule

// ==== test/icb2to1_bus_tb.sv ====
//------------------------------------------------------------
// Testbench for the two-master ICB bus.
// Drives both requesters from a stimulus file, models the
// slave memory and checks commands, responses and order.
//------------------------------------------------------------

module icb2to1_bus_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import icb_pkg::*;
  import arbt_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  typedef struct {
    int        phase;
    icb_op_e   op;
    icb_addr_t addr;
    icb_data_t wdata;
    icb_mask_t wmask;
    icb_size_t xfer_size;
    logic      exp_err;
    icb_data_t exp_rdata;
  } stim_t;

  logic      clk = 1'b0;
  logic      i_reset = 1'b1;

  // Requester side. Index is the port number.
  logic      cmd_valid [2] = '{default: 1'b0};
  logic      cmd_ready [2];
  icb_op_e   cmd_op [2] = '{default: ICB_WRITE};
  icb_addr_t cmd_addr [2] = '{default: '0};
  icb_data_t cmd_wdata [2] = '{default: '0};
  icb_mask_t cmd_wmask [2] = '{default: '0};
  icb_size_t cmd_size [2] = '{default: '0};
  logic      rsp_valid [2];
  logic      rsp_ready [2] = '{default: 1'b0};
  logic      rsp_err [2];
  icb_data_t rsp_rdata [2];

  // Slave side.
  logic      mem_cmd_valid;
  logic      mem_cmd_ready = 1'b0;
  icb_op_e   mem_cmd_op;
  icb_addr_t mem_cmd_addr;
  icb_data_t mem_cmd_wdata;
  icb_mask_t mem_cmd_wmask;
  icb_size_t mem_cmd_size;
  logic      mem_rsp_valid = 1'b0;
  logic      mem_rsp_ready;
  logic      mem_rsp_err = 1'b0;
  icb_data_t mem_rsp_rdata = '0;

  stim_t       stim0 [$];
  stim_t       stim1 [$];
  int          acc_pos [2] = '{0, 0};
  int          out_pos [2] = '{0, 0};
  int          rsp_pos [2] = '{0, 0};
  int          cur_phase = 1;
  int          last_src = -1;
  logic        slv_err_q [$];
  icb_data_t   slv_rdata_q [$];
  icb_data_t   mem_model [icb_addr_t];
  logic [31:0] lfsr_state = 32'hb59c_3aee;
  int          cmd_errors = 0;
  int          rsp_errors = 0;
  int          timeout_errors = 0;

  icb2to1_bus u_icb2to1_bus (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_i0_cmd_valid  (cmd_valid[0]),
    .o_i0_cmd_ready  (cmd_ready[0]),
    .i_i0_cmd_op     (cmd_op[0]),
    .i_i0_cmd_addr   (cmd_addr[0]),
    .i_i0_cmd_wdata  (cmd_wdata[0]),
    .i_i0_cmd_wmask  (cmd_wmask[0]),
    .i_i0_cmd_size   (cmd_size[0]),
    .o_i0_rsp_valid  (rsp_valid[0]),
    .i_i0_rsp_ready  (rsp_ready[0]),
    .o_i0_rsp_err    (rsp_err[0]),
    .o_i0_rsp_rdata  (rsp_rdata[0]),
    .i_i1_cmd_valid  (cmd_valid[1]),
    .o_i1_cmd_ready  (cmd_ready[1]),
    .i_i1_cmd_op     (cmd_op[1]),
    .i_i1_cmd_addr   (cmd_addr[1]),
    .i_i1_cmd_wdata  (cmd_wdata[1]),
    .i_i1_cmd_wmask  (cmd_wmask[1]),
    .i_i1_cmd_size   (cmd_size[1]),
    .o_i1_rsp_valid  (rsp_valid[1]),
    .i_i1_rsp_ready  (rsp_ready[1]),
    .o_i1_rsp_err    (rsp_err[1]),
    .o_i1_rsp_rdata  (rsp_rdata[1]),
    .o_mem_cmd_valid (mem_cmd_valid),
    .i_mem_cmd_ready (mem_cmd_ready),
    .o_mem_cmd_op    (mem_cmd_op),
    .o_mem_cmd_addr  (mem_cmd_addr),
    .o_mem_cmd_wdata (mem_cmd_wdata),
    .o_mem_cmd_wmask (mem_cmd_wmask),
    .o_mem_cmd_size  (mem_cmd_size),
    .i_mem_rsp_valid (mem_rsp_valid),
    .o_mem_rsp_ready (mem_rsp_ready),
    .i_mem_rsp_err   (mem_rsp_err),
    .i_mem_rsp_rdata (mem_rsp_rdata)
  );

  always #20 clk = ~clk;

  // Fibonacci LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic next_random_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  function automatic stim_t get_stim(input int p, input int i);
    if (p == 0) begin
      return stim0[i];
    end else begin
      return stim1[i];
    end
  endfunction

  function automatic int port_len(input int p);
    return (p == 0) ? stim0.size() : stim1.size();
  endfunction

  function automatic int count_phase(input int p, input int ph);
    int    n;
    stim_t s;
    n = 0;
    for (int i = 0; i < port_len(p); i++) begin
      s = get_stim(p, i);
      if (s.phase == ph) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
  endtask

  task automatic check_cmd(input stim_t exp_v, input icb_op_e op, input icb_addr_t addr,
                           input icb_data_t wdata, input icb_mask_t wmask,
                           input icb_size_t xfer_size);
    if (op !== exp_v.op) begin
      report_mismatch("o_mem_cmd_op", 32'(exp_v.op), 32'(op));
      cmd_errors++;
    end
    if (addr !== exp_v.addr) begin
      report_mismatch("o_mem_cmd_addr", exp_v.addr, addr);
      cmd_errors++;
    end
    if (wdata !== exp_v.wdata) begin
      report_mismatch("o_mem_cmd_wdata", exp_v.wdata, wdata);
      cmd_errors++;
    end
    if (wmask !== exp_v.wmask) begin
      report_mismatch("o_mem_cmd_wmask", 32'(exp_v.wmask), 32'(wmask));
      cmd_errors++;
    end
    if (xfer_size !== exp_v.xfer_size) begin
      report_mismatch("o_mem_cmd_size", 32'(exp_v.xfer_size), 32'(xfer_size));
      cmd_errors++;
    end
  endtask

  task automatic check_rsp(input int port, input logic exp_err, input logic act_err,
                           input icb_data_t exp_rdata, input icb_data_t act_rdata);
    if (act_err !== exp_err) begin
      report_mismatch($sformatf("o_i%0d_rsp_err", port), 32'(exp_err), 32'(act_err));
      rsp_errors++;
    end
    if (act_rdata !== exp_rdata) begin
      report_mismatch($sformatf("o_i%0d_rsp_rdata", port), exp_rdata, act_rdata);
      rsp_errors++;
    end
  endtask

  task automatic load_stimulus(output logic ok);
    int          fd;
    int          n;
    int          phase_v;
    int          port_v;
    int          err_v;
    string       line;
    string       op_s;
    logic [31:0] addr_v;
    logic [31:0] wdata_v;
    logic [31:0] rdata_v;
    logic [3:0]  mask_v;
    logic [1:0]  size_v;
    stim_t       s;
    ok = 1'b0;
    fd = $fopen("test/icb_stimulus.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%d %d %s %h %h %h %h %d %h", phase_v, port_v, op_s,
                      addr_v, wdata_v, mask_v, size_v, err_v, rdata_v);
          if (n == 9) begin
            s.phase     = phase_v;
            s.op        = (op_s == "R") ? ICB_READ : ICB_WRITE;
            s.addr      = addr_v;
            s.wdata     = wdata_v;
            s.wmask     = mask_v;
            s.xfer_size = size_v;
            s.exp_err   = (err_v != 0);
            s.exp_rdata = rdata_v;
            if (port_v == 0) begin
              stim0.push_back(s);
            end else begin
              stim1.push_back(s);
            end
          end
        end
      end
      $fclose(fd);
      ok = (stim0.size() > 0) && (stim1.size() > 0);
    end
  endtask

  task automatic wait_responses(input int n0, input int n1, input string what);
    int cyc;
    cyc = 0;
    while ((rsp_pos[0] < n0 || rsp_pos[1] < n1) && cyc < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cyc++;
    end
    if (rsp_pos[0] < n0 || rsp_pos[1] < n1) begin
      $display("Timeout while waiting for %s, port 0 got %0d of %0d, port 1 got %0d of %0d.",
               what, rsp_pos[0], n0, rsp_pos[1], n1);
      timeout_errors++;
    end
  endtask

  // Monitors, slave model and drivers on the rising edge.
  always @(posedge clk) begin
    stim_t     s;
    int        src;
    int        n_match;
    logic      fire;
    logic      bit_v;
    logic      err_v;
    icb_data_t rdata_v;
    icb_addr_t key;
    if (!i_reset) begin
      for (int p = 0; p < 2; p++) begin
        if (rsp_valid[p] && rsp_ready[p]) begin
          if (rsp_pos[p] >= acc_pos[p]) begin
            $display("Port %0d got a response with no command outstanding at %0t ns.",
                     p, $time);
            rsp_errors++;
          end else begin
            s = get_stim(p, rsp_pos[p]);
            check_rsp(p, s.exp_err, rsp_err[p], s.exp_rdata, rsp_rdata[p]);
            rsp_pos[p]++;
          end
        end
      end

      if (mem_cmd_valid && mem_cmd_ready) begin
        n_match = 0;
        src = 0;
        for (int p = 0; p < 2; p++) begin
          if (out_pos[p] < acc_pos[p]) begin
            s = get_stim(p, out_pos[p]);
            if (s.addr == mem_cmd_addr) begin
              n_match++;
              src = p;
            end
          end
        end
        if (n_match != 1) begin
          $display("Command to address %h at the slave matches %0d pending port commands.",
                   mem_cmd_addr, n_match);
          cmd_errors++;
        end else begin
          s = get_stim(src, out_pos[src]);
          check_cmd(s, mem_cmd_op, mem_cmd_addr, mem_cmd_wdata, mem_cmd_wmask, mem_cmd_size);
          out_pos[src]++;
          if (s.phase == 2) begin
            if (src == last_src) begin
              $display("Round robin gave port %0d two grants in a row at %0t ns.", src, $time);
              cmd_errors++;
            end
            last_src = src;
          end
        end
        // Slave memory. The error range leaves memory untouched.
        key = {mem_cmd_addr[31:2], 2'b00};
        err_v = (mem_cmd_addr >= 32'h8000_0000);
        rdata_v = '0;
        if (!err_v && mem_cmd_op == ICB_READ && mem_model.exists(key)) begin
          rdata_v = mem_model[key];
        end
        if (!err_v && mem_cmd_op == ICB_WRITE) begin
          if (!mem_model.exists(key)) begin
            mem_model[key] = '0;
          end
          for (int b = 0; b < 4; b++) begin
            if (mem_cmd_wmask[b]) begin
              mem_model[key][8*b +: 8] = mem_cmd_wdata[8*b +: 8];
            end
          end
        end
        slv_err_q.push_back(err_v);
        slv_rdata_q.push_back(rdata_v);
      end

      for (int p = 0; p < 2; p++) begin
        fire = cmd_valid[p] && cmd_ready[p];
        if (fire) begin
          acc_pos[p]++;
        end
        if (!cmd_valid[p] || fire) begin
          next_random_bit(bit_v);
          cmd_valid[p] <= 1'b0;
          if (acc_pos[p] < port_len(p)) begin
            s = get_stim(p, acc_pos[p]);
            // Phase 2 holds valid without gaps.
            if (s.phase <= cur_phase && (s.phase == 2 || bit_v)) begin
              cmd_valid[p] <= 1'b1;
              cmd_op[p]    <= s.op;
              cmd_addr[p]  <= s.addr;
              cmd_wdata[p] <= s.wdata;
              cmd_wmask[p] <= s.wmask;
              cmd_size[p]  <= s.xfer_size;
            end
          end
        end
        next_random_bit(bit_v);
        rsp_ready[p] <= bit_v;
      end

      next_random_bit(bit_v);
      mem_cmd_ready <= bit_v;

      fire = mem_rsp_valid && mem_rsp_ready;
      if (fire) begin
        void'(slv_err_q.pop_front());
        void'(slv_rdata_q.pop_front());
      end
      if (!mem_rsp_valid || fire) begin
        next_random_bit(bit_v);
        if (slv_err_q.size() > 0 && bit_v) begin
          mem_rsp_valid <= 1'b1;
          mem_rsp_err   <= slv_err_q[0];
          mem_rsp_rdata <= slv_rdata_q[0];
        end else begin
          mem_rsp_valid <= 1'b0;
        end
      end
    end
  end

  initial begin
    logic ok;
    load_stimulus(ok);
    repeat (3) @(posedge clk);
    i_reset <= 1'b0;
    if (ok) begin
      wait_responses(count_phase(0, 1), count_phase(1, 1), "phase 1 responses");
      if (timeout_errors == 0) begin
        cur_phase <= 2;
        wait_responses(port_len(0), port_len(1), "phase 2 responses");
      end
      // Idle cycles to catch any extra response.
      repeat (10) @(negedge clk);
    end else begin
      $display("Stimulus file could not be read or holds no commands for a port.");
    end
    $display("Errors: command %0d, response %0d, timeout %0d",
             cmd_errors, rsp_errors, timeout_errors);
    if (ok && cmd_errors == 0 && rsp_errors == 0 && timeout_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== test/icb_stimulus.txt ====
# phase port op addr wdata wmask size exp_err exp_rdata
# op is W or R; addr, wdata, wmask, size and exp_rdata are hex
1 0 W 00000100 11223344 f 2 0 00000000
1 0 R 00000100 00000000 0 2 0 11223344
1 0 W 00000104 aabbccdd 3 1 0 00000000
1 0 R 00000104 00000000 0 2 0 0000ccdd
1 0 W 00000100 000000ee 1 0 0 00000000
1 0 R 00000108 00000000 0 2 0 00000000
1 0 R 80000010 00000000 0 2 1 00000000
1 0 W 80000014 12345678 f 2 1 00000000
1 0 R 00000100 00000000 0 2 0 112233ee
1 1 W 00000200 deadbeef f 2 0 00000000
1 1 W 00000200 00550000 4 0 0 00000000
1 1 R 00000200 00000000 0 2 0 de55beef
1 1 R 80000020 00000000 0 2 1 00000000
1 1 W 00000204 cafef00d c 1 0 00000000
1 1 R 00000204 00000000 0 2 0 cafe0000
1 1 R 0000020c 00000000 0 2 0 00000000
2 0 R 00000100 00000000 0 2 0 112233ee
2 0 R 00000104 00000000 0 2 0 0000ccdd
2 0 R 00000108 00000000 0 2 0 00000000
2 0 R 8000001c 00000000 0 2 1 00000000
2 1 R 00000200 00000000 0 2 0 de55beef
2 1 R 00000204 00000000 0 2 0 cafe0000
2 1 R 00000208 00000000 0 2 0 00000000
2 1 R 80000024 00000000 0 2 1 00000000

// ==== icb2to1_bus.f ====
common/icb_pkg.sv
common/arbt_pkg.sv
icb_arbt/icb_arbt.sv
icb_arbt/icb_rsp_route.sv
rtl/icb_buffer.sv
rtl/icb2to1_bus.sv
test/icb2to1_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the two-master ICB bus.

VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := icb2to1_bus_tb
FILELIST  := icb2to1_bus.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTBENCH PASSED

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail is taken from the simulator output.
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
